/* rtl/umi_ram_pkg.sv */
package umi_ram_pkg;

   //##########################################################################
   //# Command opcodes
   //##########################################################################

   // Request and response opcodes, UMI-style odd/even split
   typedef enum logic [3:0] {
      OP_READ         = 4'h1,   // Read one word
      OP_RESP_READ    = 4'h2,   // Read data return
      OP_WRITE        = 4'h3,   // Write, acknowledged
      OP_RESP_WRITE   = 4'h4,   // Write acknowledge
      OP_POSTED_WRITE = 4'h5    // Write, no response
   } umi_opcode_e;

   //##########################################################################
   //# Width defaults
   //##########################################################################

   // Command field is the opcode alone
   localparam int UMI_CW_DEFAULT       = $bits(umi_opcode_e);
   localparam int UMI_AW_DEFAULT       = 32;   // Address width
   localparam int UMI_DW_DEFAULT       = 64;   // Data width
   localparam int UMI_RAMDEPTH_DEFAULT = 256;  // Words in the array

   //##########################################################################
   //# Port tag helper
   //##########################################################################

   // Bits needed for a port index out of n ports
   // Never below one, so a single port still gets a tag wire
   function automatic int umi_tag_w(input int n);
      int w;
      w = 1;
      if (n > 2) begin
         w = $clog2(n);
      end
      return w;
   endfunction

   // Same sizing reused for the rotating pointer of the arbiter
   // and for tag compares in the mux and router

endpackage

/* rtl/umi_if.sv */
`timescale 1ns/1ps

// One valid/ready UMI channel plus the port tag
interface umi_if #(
   parameter int AW = umi_ram_pkg::UMI_AW_DEFAULT,
   parameter int DW = umi_ram_pkg::UMI_DW_DEFAULT,
   parameter int TW = 1
) ();
   import umi_ram_pkg::*;

   logic             valid;     // Sender has a packet
   umi_opcode_e      cmd;       // Opcode
   logic [AW-1:0]    dstaddr;   // Target address
   logic [AW-1:0]    srcaddr;   // Return address
   logic [DW-1:0]    data;      // Payload
   logic [TW-1:0]    tag;       // Port index, echoed back unchanged
   logic             ready;     // Receiver can take it

   // Side that sends the packet
   modport requester (
      output valid, cmd, dstaddr, srcaddr, data, tag,
      input  ready
   );

   // Side that accepts the packet
   modport responder (
      input  valid, cmd, dstaddr, srcaddr, data, tag,
      output ready
   );

   // Transfer on a rising clk edge with valid and ready both high
   // Fields stay put while valid waits for ready

endinterface

/* rtl/umi_port_arbiter.sv */
`timescale 1ns/1ps

module umi_port_arbiter #(
   parameter int N = 4                 // Number of ports
) (
   input  logic          clk,
   input  logic          rst_n,
   input  logic [N-1:0]  requests,     // Port valids
   input  logic          accept,       // Granted request transferred
   output logic [N-1:0]  grants        // One-hot, or zero when idle
);
   import umi_ram_pkg::*;

   localparam int PW = umi_tag_w(N);   // Pointer width

   logic [PW-1:0]  ptr;                // Highest priority port
   logic [PW-1:0]  winner;             // Index of the granted port
   logic [PW-1:0]  ptr_next;           // One past the winner

   //##########################################################################
   //# Grant search
   //##########################################################################

   // First requester at or after ptr, wrapping past N-1
   always_comb begin
      int   idx;
      logic found;
      grants = '0;
      winner = '0;
      found  = 1'b0;
      for (int k = 0; k < N; k++) begin
         idx = int'(ptr) + k;
         if (idx >= N) begin
            idx = idx - N;               // Wrap around
         end
         if (!found && requests[idx]) begin
            grants[idx] = 1'b1;
            winner      = PW'(idx);
            found       = 1'b1;          // Lower priority ports lose
         end
      end
   end

   //##########################################################################
   //# Rotating priority
   //##########################################################################

   // Winner drops to lowest priority next round
   always_comb begin
      if (winner == PW'(N - 1)) begin
         ptr_next = '0;
      end else begin
         ptr_next = winner + 1'b1;
      end
   end

   // Only moves on a real transfer, a stalled grant keeps its slot
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ptr <= '0;                      // Port 0 first after reset
      end else if (accept) begin
         ptr <= ptr_next;
      end
   end

   // A port holding valid waits at most N-1 other transfers

endmodule

/* rtl/umi_req_mux.sv */
`timescale 1ns/1ps

module umi_req_mux #(
   parameter int N  = 4,
   parameter int AW = umi_ram_pkg::UMI_AW_DEFAULT,
   parameter int DW = umi_ram_pkg::UMI_DW_DEFAULT
) (
   input  logic [N-1:0]                             grants,
   input  logic [N*umi_ram_pkg::UMI_CW_DEFAULT-1:0] cmd,
   input  logic [N*AW-1:0]                          dstaddr,
   input  logic [N*AW-1:0]                          srcaddr,
   input  logic [N*DW-1:0]                          data,
   output logic [N-1:0]                             port_ready,
   umi_if.requester                                 mem_req
);
   import umi_ram_pkg::*;

   localparam int CW = UMI_CW_DEFAULT;
   localparam int TW = umi_tag_w(N);

   logic [CW-1:0]  cmd_sel;
   logic [AW-1:0]  dst_sel;
   logic [AW-1:0]  src_sel;
   logic [DW-1:0]  data_sel;
   logic [TW-1:0]  tag_sel;

   // AND-OR select, grant is one-hot so at most one term survives
   always_comb begin
      cmd_sel  = '0;
      dst_sel  = '0;
      src_sel  = '0;
      data_sel = '0;
      tag_sel  = '0;
      for (int i = 0; i < N; i++) begin
         if (grants[i]) begin
            cmd_sel  = cmd_sel  | cmd[i*CW +: CW];
            dst_sel  = dst_sel  | dstaddr[i*AW +: AW];
            src_sel  = src_sel  | srcaddr[i*AW +: AW];
            data_sel = data_sel | data[i*DW +: DW];
            tag_sel  = tag_sel  | TW'(i);     // Encode grant into tag
         end
      end
   end

   assign mem_req.valid   = |grants;                    // Any grant means a packet
   assign mem_req.cmd     = umi_opcode_e'(cmd_sel);
   assign mem_req.dstaddr = dst_sel;
   assign mem_req.srcaddr = src_sel;
   assign mem_req.data    = data_sel;
   assign mem_req.tag     = tag_sel;

   // Only the granted port sees ready
   assign port_ready = grants & {N{mem_req.ready}};

endmodule

/* rtl/umi_mem_agent.sv */
`timescale 1ns/1ps

module umi_mem_agent #(
   parameter int AW       = umi_ram_pkg::UMI_AW_DEFAULT,
   parameter int DW       = umi_ram_pkg::UMI_DW_DEFAULT,
   parameter int RAMDEPTH = umi_ram_pkg::UMI_RAMDEPTH_DEFAULT
) (
   input  logic     clk,
   input  logic     rst_n,
   umi_if.responder req,     // From the request mux
   umi_if.requester resp     // To the response router
);
   import umi_ram_pkg::*;

   // Word index bits, taken from the low end of dstaddr
   localparam int IW = (RAMDEPTH > 1) ? $clog2(RAMDEPTH) : 1;

   logic [DW-1:0]  mem_array [RAMDEPTH];   // Single ported storage
   logic [IW-1:0]  word_idx;
   logic           accept;                 // Request transfers this cycle
   logic           mem_wr;                 // Store req.data
   logic           mem_rd;                 // Return stored word
   logic           rsp_load;               // Fill response register
   umi_opcode_e    rsp_cmd;                // Opcode for the response

   assign word_idx = req.dstaddr[IW-1:0];

   //##########################################################################
   //# Handshake
   //##########################################################################

   // Room when the register is empty or draining this same edge
   assign req.ready = ~resp.valid | resp.ready;
   assign accept    = req.valid & req.ready;

   //##########################################################################
   //# Command decode
   //##########################################################################

   always_comb begin
      mem_wr   = 1'b0;
      mem_rd   = 1'b0;
      rsp_load = 1'b0;
      rsp_cmd  = OP_RESP_WRITE;
      if (accept) begin
         case (req.cmd)
            OP_READ: begin
               mem_rd   = 1'b1;
               rsp_load = 1'b1;
               rsp_cmd  = OP_RESP_READ;
            end
            OP_WRITE: begin
               mem_wr   = 1'b1;
               rsp_load = 1'b1;          // Acknowledge goes back
               rsp_cmd  = OP_RESP_WRITE;
            end
            OP_POSTED_WRITE: begin
               mem_wr   = 1'b1;          // Silent store
            end
            default: begin
               // Unknown opcode, swallowed without a response
            end
         endcase
      end
   end

   //##########################################################################
   //# Memory array
   //##########################################################################

   // One access per cycle, so a read never races a write
   always_ff @(posedge clk) begin
      if (mem_wr) begin
         mem_array[word_idx] <= req.data;
      end
   end

   //##########################################################################
   //# Response register
   //##########################################################################

   // Control bit
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         resp.valid <= 1'b0;
      end else if (rsp_load) begin
         resp.valid <= 1'b1;             // New response, possibly back to back
      end else if (resp.ready) begin
         resp.valid <= 1'b0;             // Drained
      end
   end

   // Payload, only loaded alongside a new response
   always_ff @(posedge clk) begin
      if (rsp_load) begin
         resp.cmd     <= rsp_cmd;
         resp.dstaddr <= req.srcaddr;   // Reply goes to the asker
         resp.srcaddr <= req.dstaddr;   // From the accessed location
         resp.tag     <= req.tag;       // Port index rides along
         if (mem_rd) begin
            resp.data <= mem_array[word_idx];   // Word before this edge
         end else begin
            resp.data <= req.data;              // Ack echoes the write data
         end
      end
   end

endmodule

/* rtl/umi_resp_router.sv */
`timescale 1ns/1ps

module umi_resp_router #(
   parameter int N  = 4,
   parameter int AW = umi_ram_pkg::UMI_AW_DEFAULT,
   parameter int DW = umi_ram_pkg::UMI_DW_DEFAULT
) (
   umi_if.responder                                 resp,
   output logic [N-1:0]                             resp_valid,
   output logic [N*umi_ram_pkg::UMI_CW_DEFAULT-1:0] resp_cmd,
   output logic [N*AW-1:0]                          resp_dstaddr,
   output logic [N*AW-1:0]                          resp_srcaddr,
   output logic [N*DW-1:0]                          resp_data,
   input  logic [N-1:0]                             resp_ready
);
   import umi_ram_pkg::*;

   localparam int CW = UMI_CW_DEFAULT;
   localparam int TW = umi_tag_w(N);

   logic [N-1:0]   port_hit;   // Tag decoded to one-hot
   logic [CW-1:0]  cmd_bits;

   // Tag back to one-hot port select
   always_comb begin
      for (int i = 0; i < N; i++) begin
         port_hit[i] = (resp.tag == TW'(i));
      end
   end

   // Valid only on the asking port
   assign resp_valid = port_hit & {N{resp.valid}};

   // Fields go to every port, the valid picks the owner
   assign cmd_bits     = resp.cmd;
   assign resp_cmd     = {N{cmd_bits}};
   assign resp_dstaddr = {N{resp.dstaddr}};
   assign resp_srcaddr = {N{resp.srcaddr}};
   assign resp_data    = {N{resp.data}};

   // Addressed port's ready, or free when nothing is pending
   assign resp.ready = |(port_hit & resp_ready) | ~resp.valid;

endmodule

/* rtl/umi_ram.sv */
`timescale 1ns/1ps

module umi_ram #(
   parameter int N        = 4,                                   // UMI ports
   parameter int AW       = umi_ram_pkg::UMI_AW_DEFAULT,         // Address width
   parameter int DW       = umi_ram_pkg::UMI_DW_DEFAULT,         // Data width
   parameter int RAMDEPTH = umi_ram_pkg::UMI_RAMDEPTH_DEFAULT    // Words
) (
   input  logic                                     clk,
   input  logic                                     rst_n,
   // Requests in, one slice per port
   input  logic [N-1:0]                             req_valid,
   input  logic [N*umi_ram_pkg::UMI_CW_DEFAULT-1:0] req_cmd,
   input  logic [N*AW-1:0]                          req_dstaddr,
   input  logic [N*AW-1:0]                          req_srcaddr,
   input  logic [N*DW-1:0]                          req_data,
   output logic [N-1:0]                             req_ready,
   // Responses out, one slice per port
   output logic [N-1:0]                             resp_valid,
   output logic [N*umi_ram_pkg::UMI_CW_DEFAULT-1:0] resp_cmd,
   output logic [N*AW-1:0]                          resp_dstaddr,
   output logic [N*AW-1:0]                          resp_srcaddr,
   output logic [N*DW-1:0]                          resp_data,
   input  logic [N-1:0]                             resp_ready
);
   import umi_ram_pkg::*;

   localparam int TW = umi_tag_w(N);   // Port tag width

   logic [N-1:0]  grants;              // One-hot winner
   logic          req_accept;          // Request handed to the agent

   // Internal channels
   umi_if #(.AW(AW), .DW(DW), .TW(TW)) mem_req ();
   umi_if #(.AW(AW), .DW(DW), .TW(TW)) mem_resp ();

   assign req_accept = mem_req.valid & mem_req.ready;

   //##########################################################################
   //# Request path
   //##########################################################################

   umi_port_arbiter #(
      .N (N)
   ) umi_port_arbiter (
      .clk      (clk),
      .rst_n    (rst_n),
      .requests (req_valid),
      .accept   (req_accept),
      .grants   (grants)
   );

   umi_req_mux #(
      .N  (N),
      .AW (AW),
      .DW (DW)
   ) umi_req_mux (
      .grants     (grants),
      .cmd        (req_cmd),
      .dstaddr    (req_dstaddr),
      .srcaddr    (req_srcaddr),
      .data       (req_data),
      .port_ready (req_ready),        // Ready gated per grant
      .mem_req    (mem_req.requester)
   );

   //##########################################################################
   //# Memory and response path
   //##########################################################################

   umi_mem_agent #(
      .AW       (AW),
      .DW       (DW),
      .RAMDEPTH (RAMDEPTH)
   ) umi_mem_agent (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (mem_req.responder),
      .resp  (mem_resp.requester)
   );

   umi_resp_router #(
      .N  (N),
      .AW (AW),
      .DW (DW)
   ) umi_resp_router (
      .resp         (mem_resp.responder),
      .resp_valid   (resp_valid),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .resp_ready   (resp_ready)
   );

endmodule

/* testbench/tb_umi_ram.sv */
`timescale 1ns/1ps

module tb_umi_ram;
   import umi_ram_pkg::*;

   localparam int N          = 3;
   localparam int AW         = 32;
   localparam int DW         = 64;
   localparam int RAMDEPTH   = 256;
   localparam int CW         = UMI_CW_DEFAULT;
   localparam int IW         = $clog2(RAMDEPTH);   // Word index bits
   localparam int CLK_PERIOD = 40;
   localparam int TIMEOUT    = 40;                 // Cycles before a wait gives up

   logic              clk;
   logic              rst_n;
   logic [N-1:0]      req_valid;
   logic [N*CW-1:0]   req_cmd;
   logic [N*AW-1:0]   req_dstaddr;
   logic [N*AW-1:0]   req_srcaddr;
   logic [N*DW-1:0]   req_data;
   logic [N-1:0]      req_ready;
   logic [N-1:0]      resp_valid;
   logic [N*CW-1:0]   resp_cmd;
   logic [N*AW-1:0]   resp_dstaddr;
   logic [N*AW-1:0]   resp_srcaddr;
   logic [N*DW-1:0]   resp_data;
   logic [N-1:0]      resp_ready;

   logic [DW-1:0]     ref_mem [RAMDEPTH];   // Expected array contents
   logic [DW-1:0]     exp_data [N];         // Read data each port waits for
   umi_opcode_e       got_cmd;              // Last captured response
   logic [AW-1:0]     got_dst;
   logic [AW-1:0]     got_src;
   logic [DW-1:0]     got_data;
   int                err_count;
   int                timeout_count;

   umi_ram #(.N(N), .AW(AW), .DW(DW), .RAMDEPTH(RAMDEPTH)) UUT (
      .clk (clk), .rst_n (rst_n),
      .req_valid (req_valid), .req_cmd (req_cmd), .req_dstaddr (req_dstaddr),
      .req_srcaddr (req_srcaddr), .req_data (req_data), .req_ready (req_ready),
      .resp_valid (resp_valid), .resp_cmd (resp_cmd), .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr), .resp_data (resp_data), .resp_ready (resp_ready)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   //##########################################################################
   //# Compare tasks
   //##########################################################################

   task automatic check_opcode(string name, umi_opcode_e exp, umi_opcode_e act);
      if (act !== exp) begin
         $display("FAILED %s: expected %s, got %s (%h)", name, exp.name(), act.name(), act);
         err_count++;
      end
   endtask

   task automatic check_data(string name, logic [DW-1:0] exp, logic [DW-1:0] act);
      if (act !== exp) begin
         $display("FAILED %s: expected %h, got %h", name, exp, act);
         err_count++;
      end
   endtask

   task automatic check_addr(string name, logic [AW-1:0] exp, logic [AW-1:0] act);
      if (act !== exp) begin
         $display("FAILED %s: expected %h, got %h", name, exp, act);
         err_count++;
      end
   endtask

   task automatic check_port(string name, logic [N-1:0] exp, logic [N-1:0] act);
      if (act !== exp) begin
         $display("FAILED %s: expected %b, got %b", name, exp, act);
         err_count++;
      end
   endtask

   //##########################################################################
   //# Port drivers
   //##########################################################################

   function automatic logic [N-1:0] port_bit(int p);
      logic [N-1:0] v;
      v    = '0;
      v[p] = 1'b1;
      return v;
   endfunction

   // Quarter period past the falling edge where outputs have settled
   task automatic settle();
      #(CLK_PERIOD/4);
   endtask

   // Offer one request, hold it until ready, return at the next falling edge
   task automatic send_req(string name, int p, umi_opcode_e op, logic [AW-1:0] dst,
                           logic [AW-1:0] src, logic [DW-1:0] data);
      int cycles;
      cycles = 0;
      @(negedge clk);
      req_cmd[p*CW +: CW]     = op;
      req_dstaddr[p*AW +: AW] = dst;
      req_srcaddr[p*AW +: AW] = src;
      req_data[p*DW +: DW]    = data;
      req_valid[p]            = 1'b1;
      settle();
      while (!req_ready[p] && cycles < TIMEOUT) begin
         @(negedge clk);
         settle();
         cycles++;
      end
      if (!req_ready[p]) begin
         $display("Timeout in %s: port %0d request was never accepted", name, p);
         timeout_count++;
      end
      @(negedge clk);                        // Transfer happened on the edge just passed
      req_valid[p] = 1'b0;
   endtask

   // Wait for the response on port p and capture its fields
   task automatic wait_resp(string name, int p);
      int cycles;
      cycles = 0;
      settle();
      while (!resp_valid[p] && cycles < TIMEOUT) begin
         @(negedge clk);
         settle();
         cycles++;
      end
      if (!resp_valid[p]) begin
         $display("Timeout in %s: no response arrived on port %0d", name, p);
         timeout_count++;
      end
      check_port(name, port_bit(p), resp_valid);   // Only the asking port
      got_cmd  = umi_opcode_e'(resp_cmd[p*CW +: CW]);
      got_dst  = resp_dstaddr[p*AW +: AW];
      got_src  = resp_srcaddr[p*AW +: AW];
      got_data = resp_data[p*DW +: DW];
   endtask

   task automatic write_mem(string name, int p, logic [AW-1:0] addr, logic [DW-1:0] data);
      logic [AW-1:0] src;
      src = $urandom;
      send_req(name, p, OP_WRITE, addr, src, data);
      ref_mem[addr[IW-1:0]] = data;
      wait_resp(name, p);
      check_opcode(name, OP_RESP_WRITE, got_cmd);
      check_addr(name, src, got_dst);        // Addresses come back swapped
      check_addr(name, addr, got_src);
   endtask

   task automatic read_mem(string name, int p, logic [AW-1:0] addr);
      logic [AW-1:0] src;
      src = $urandom;
      send_req(name, p, OP_READ, addr, src, '0);
      wait_resp(name, p);
      check_opcode(name, OP_RESP_READ, got_cmd);
      check_data(name, ref_mem[addr[IW-1:0]], got_data);
      check_addr(name, src, got_dst);
      check_addr(name, addr, got_src);
   endtask

   // Read fields for port p while the caller drives valid
   task automatic load_read(int p, logic [AW-1:0] addr);
      req_cmd[p*CW +: CW]     = OP_READ;
      req_dstaddr[p*AW +: AW] = addr;
      req_srcaddr[p*AW +: AW] = $urandom;
      exp_data[p]             = ref_mem[addr[IW-1:0]];
   endtask

   // Ports in the mask keep requesting until the given number of transfers
   task automatic race_ports(string name, logic [N-1:0] ports, int transfers);
      int           served [N];
      int           xfers;
      int           resps;
      int           cycles;
      logic [N-1:0] once;
      xfers  = 0;
      resps  = 0;
      cycles = 0;
      foreach (served[i]) begin
         served[i] = 0;
      end
      while ((xfers < transfers || resps < transfers) && cycles < TIMEOUT) begin
         settle();
         for (int p = 0; p < N; p++) begin
            if (resp_valid[p]) begin
               check_opcode(name, OP_RESP_READ, umi_opcode_e'(resp_cmd[p*CW +: CW]));
               check_data(name, exp_data[p], resp_data[p*DW +: DW]);
               if (ports[p]) begin
                  resps++;
               end
            end
            if (ports[p] && req_valid[p] && req_ready[p]) begin
               served[p]++;                  // Transfers on the coming edge
               xfers++;
            end
         end
         @(negedge clk);
         if (xfers >= transfers) begin
            req_valid = req_valid & ~ports;
         end
         cycles++;
      end
      if (xfers < transfers || resps < transfers) begin
         $display("Timeout in %s: %0d transfers and %0d responses seen", name, xfers, resps);
         timeout_count++;
      end
      once = '0;
      for (int p = 0; p < N; p++) begin
         once[p] = (served[p] == 1);
      end
      check_port(name, ports, once);         // Each port exactly once
   endtask

   //##########################################################################
   //# Directed tests
   //##########################################################################

   task automatic test_basic();
      logic [AW-1:0] addr;
      addr = $urandom;
      @(negedge clk);
      settle();
      check_port("reset_idle", '0, resp_valid);
      write_mem("basic_write", 0, addr, {$urandom, $urandom});
      read_mem("basic_read", 0, addr);
   endtask

   task automatic test_posted();
      logic [AW-1:0] addr;
      logic [DW-1:0] data;
      addr = $urandom;
      data = {$urandom, $urandom};
      send_req("posted_write", 1, OP_POSTED_WRITE, addr, $urandom, data);
      ref_mem[addr[IW-1:0]] = data;
      repeat (10) begin
         settle();
         check_port("posted_silent", '0, resp_valid);   // Nothing comes back
         @(negedge clk);
      end
      read_mem("posted_read", 2, addr);
   endtask

   task automatic test_random();
      logic [AW-1:0] addrs [8];
      for (int i = 0; i < 8; i++) begin
         addrs[i] = $urandom;
         write_mem("random_write", i % N, addrs[i], {$urandom, $urandom});
      end
      // Read back through a different port than the writer
      for (int i = 0; i < 8; i++) begin
         read_mem("random_read", (i + 1) % N, addrs[i]);
      end
   endtask

   task automatic test_fairness();
      logic [AW-1:0] addr [N];
      for (int p = 0; p < N; p++) begin
         addr[p] = AW'((p + 1) * 8);
         write_mem("fair_setup", p, addr[p], {$urandom, $urandom});
      end
      @(negedge clk);
      for (int p = 0; p < N; p++) begin
         load_read(p, addr[p]);
      end
      req_valid = '1;                        // All ports at once and held
      race_ports("fairness", '1, N);
   endtask

   task automatic test_backpressure();
      logic [AW-1:0] addr;
      addr = AW'(8'h40);
      for (int p = 0; p < N; p++) begin
         write_mem("stall_setup", p, addr + AW'(p), {$urandom, $urandom});
      end
      @(negedge clk);
      resp_ready[0] = 1'b0;
      send_req("stall_read", 0, OP_READ, addr, $urandom, '0);
      exp_data[0] = ref_mem[addr[IW-1:0]];
      for (int p = 1; p < N; p++) begin
         load_read(p, addr + AW'(p));        // Own word per port
         req_valid[p] = 1'b1;
      end
      repeat (6) begin
         settle();
         check_port("stall_ready", '0, req_ready);       // Everyone blocked
         check_port("stall_valid", port_bit(0), resp_valid);
         check_data("stall_data", exp_data[0], resp_data[DW-1:0]);
         @(negedge clk);
      end
      resp_ready[0] = 1'b1;                  // Release the held response
      race_ports("stall_release", ~port_bit(0), N - 1);
   endtask

   initial begin
      void'($urandom(32'hb3ba5e76));
      err_count     = 0;
      timeout_count = 0;
      clk           = 1'b0;
      rst_n         = 1'b0;
      req_valid     = '0;
      req_cmd       = '0;
      req_dstaddr   = '0;
      req_srcaddr   = '0;
      req_data      = '0;
      resp_ready    = '1;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      test_basic();
      test_posted();
      test_random();
      test_fairness();
      test_backpressure();
      $display("Errors: %0d failed checks, %0d timeouts", err_count, timeout_count);
      if (err_count == 0 && timeout_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

/* umi_ram.f */
rtl/umi_ram_pkg.sv
rtl/umi_if.sv
rtl/umi_port_arbiter.sv
rtl/umi_req_mux.sv
rtl/umi_mem_agent.sv
rtl/umi_resp_router.sv
rtl/umi_ram.sv
testbench/tb_umi_ram.sv

/* Bender.yml */
package:
  name: umi_ram

sources:
  - files:
      - rtl/umi_ram_pkg.sv
      - rtl/umi_if.sv
      - rtl/umi_port_arbiter.sv
      - rtl/umi_req_mux.sv
      - rtl/umi_mem_agent.sv
      - rtl/umi_resp_router.sv
      - rtl/umi_ram.sv
  - target: test
    files:
      - testbench/tb_umi_ram.sv
